// ==== hw/hv_macros.svh ====
`ifndef HV_MACROS_SVH
`define HV_MACROS_SVH

// hypervector width in bits, power of two and a multiple of the chunk width
`define HV_DIM 256

// random chunk width fed in from outside
`define HV_CHUNK 32

// item memory depth
`define HV_ITEMS 512

// hardware threads, two or more
`define HV_THREADS 5

// instruction word width
`define HV_INST_W 16

`endif

// ==== hw/hv_data_pkg.sv ====
`default_nettype none

`include "hv_macros.svh"

package hv_data_pkg;

    // one full hypervector
    typedef logic [`HV_DIM-1:0] hv_vec_t;

    // one random chunk from outside
    typedef logic [`HV_CHUNK-1:0] hv_chunk_t;

    // item memory address
    typedef logic [$clog2(`HV_ITEMS)-1:0] item_addr_t;

    // thread number, fixed at 3 bits by the encoding
    typedef logic [2:0] thread_idx_t;

    // rotate amount field of an op
    typedef logic [9:0] rot_amt_t;

endpackage

`default_nettype wire

// ==== hw/hv_inst_pkg.sv ====
`default_nettype none

`include "hv_macros.svh"

package hv_inst_pkg;

    import hv_data_pkg::*;

    // one instruction word, read as a load or as an op
    // bit 15 is is_load in both views
    typedef union packed {
        // load r2 from item memory
        struct packed {
            logic                                        is_load;
            logic [`HV_INST_W-$bits(item_addr_t)-2:0]    unused;
            item_addr_t                                  item_addr;
        } ld;
        // rotate / xor / writeback / store / last
        struct packed {
            logic       is_load;
            logic       rotate;
            logic       wr_r2;
            logic       store;
            logic       wr_r1;
            // ignored when store is also set
            logic       last;
            rot_amt_t   rot_amt;
        } op;
    } hv_inst_u;

endpackage

`default_nettype wire

// ==== hw/hv_item_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "hv_macros.svh"

module hv_item_memory
    import hv_data_pkg::*;
(
    input  wire              clk,
    input  wire              arst_n,
    input  wire              load_mode,
    input  wire              chunk_valid,
    input  wire hv_chunk_t   chunk,
    input  wire item_addr_t  rd_addr,
    output hv_vec_t          rd_data
);

    localparam int unsigned SLOTS  = `HV_DIM / `HV_CHUNK;
    localparam int unsigned SLOT_W = $clog2(SLOTS);

    logic [SLOT_W-1:0] slot;
    logic              asm_full;
    item_addr_t        wr_addr;
    hv_vec_t           asm_vec;
    hv_vec_t           mem [`HV_ITEMS];

    // slot counter, write address and the write request
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            slot     <= '0;
            asm_full <= 1'b0;
            wr_addr  <= '0;
        end else if (!load_mode) begin
            slot     <= '0;
            asm_full <= 1'b0;
            wr_addr  <= '0;
        end else begin
            // last slot filled, write the vector next edge
            asm_full <= chunk_valid && (&slot);
            if (chunk_valid) begin
                // SLOTS is a power of two, so this wraps to slot 0
                slot <= slot + 1'b1;
            end
            if (asm_full) begin
                wr_addr <= wr_addr + 1'b1;
            end
        end
    end

    // first chunk lands in the lowest bits
    always_ff @(posedge clk) begin
        if (!load_mode) begin
            asm_vec <= '0;
        end else if (chunk_valid) begin
            asm_vec[slot*`HV_CHUNK +: `HV_CHUNK] <= chunk;
        end
    end

    // write of a completed vector, read every cycle
    always_ff @(posedge clk) begin
        if (asm_full) begin
            mem[wr_addr] <= asm_vec;
        end
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// ==== hw/hv_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "hv_macros.svh"

module hv_decode
    import hv_data_pkg::*;
    import hv_inst_pkg::*;
(
    input  wire               clk,
    input  wire               arst_n,
    input  wire               run,
    input  wire               inst_valid,
    input  wire hv_inst_u     inst,
    output thread_idx_t       rd_thread,
    output logic              ex_valid,
    output hv_inst_u          ex_inst,
    output thread_idx_t       ex_thread
);

    localparam thread_idx_t LAST_THREAD = thread_idx_t'(`HV_THREADS - 1);

    thread_idx_t thread;

    // round-robin thread counter and the execute strobe
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            thread   <= '0;
            ex_valid <= 1'b0;
        end else if (!run) begin
            thread   <= '0;
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= inst_valid;
            if (inst_valid) begin
                if (thread == LAST_THREAD) begin
                    thread <= '0;
                end else begin
                    thread <= thread + 1'b1;
                end
            end
        end
    end

    // instruction register, only meaningful with ex_valid
    always_ff @(posedge clk) begin
        if (run && inst_valid) begin
            ex_inst   <= inst;
            ex_thread <= thread;
        end
    end

    // register files are read with the thread before it advances
    assign rd_thread = thread;

endmodule

`default_nettype wire

// ==== hw/hv_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "hv_macros.svh"

module hv_execute
    import hv_data_pkg::*;
    import hv_inst_pkg::*;
(
    input  wire                clk,
    input  wire                ex_valid,
    input  wire hv_inst_u      ex_inst,
    input  wire thread_idx_t   ex_thread,
    input  wire thread_idx_t   rd_thread,
    input  wire hv_vec_t       item_data,
    output hv_vec_t            store_vec,
    output logic               do_store,
    output logic               do_last
);

    // rotate modulo HV_DIM, HV_DIM is a power of two
    localparam int unsigned ROT_W = $clog2(`HV_DIM);

    hv_vec_t                r1_mem [`HV_THREADS];
    hv_vec_t                r2_mem [`HV_THREADS];
    hv_vec_t                r1_q;
    hv_vec_t                r2_q;
    hv_vec_t                work;
    logic [ROT_W-1:0]       amt;
    logic [2*`HV_DIM-1:0]   dbl;
    logic                   is_op;

    // synchronous read of both files for the thread in decode
    always_ff @(posedge clk) begin
        r1_q <= r1_mem[rd_thread];
        r2_q <= r2_mem[rd_thread];
    end

    // working value, r2 rotated left when asked
    always_comb begin
        amt  = ex_inst.op.rot_amt[ROT_W-1:0];
        dbl  = {r2_q, r2_q} << amt;
        work = ex_inst.op.rotate ? dbl[2*`HV_DIM-1 -: `HV_DIM] : r2_q;
    end

    assign is_op = ex_valid && !ex_inst.ld.is_load;

    // writeback, both writes see the values read before
    always_ff @(posedge clk) begin
        if (ex_valid && ex_inst.ld.is_load) begin
            r2_mem[ex_thread] <= item_data;
        end
        if (is_op && ex_inst.op.wr_r2) begin
            // bind r1 into the rotated r2
            r2_mem[ex_thread] <= r1_q ^ work;
        end
        if (is_op && ex_inst.op.wr_r1) begin
            r1_mem[ex_thread] <= work;
        end
    end

    // store wins over last
    assign do_store  = is_op && ex_inst.op.store;
    assign do_last   = is_op && !ex_inst.op.store && ex_inst.op.last;
    assign store_vec = work;

endmodule

`default_nettype wire

// ==== hw/hv_result.sv ====
`timescale 1ns/1ps
`default_nettype none

module hv_result
    import hv_data_pkg::*;
(
    input  wire             clk,
    input  wire             arst_n,
    input  wire             run,
    input  wire             do_store,
    input  wire             do_last,
    input  wire hv_vec_t    store_vec,
    output logic            result_valid,
    output logic            last,
    output hv_vec_t         result
);

    hv_vec_t store_buf;

    // one-cycle strobes
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            result_valid <= 1'b0;
            last         <= 1'b0;
        end else if (!run) begin
            result_valid <= 1'b0;
            last         <= 1'b0;
        end else begin
            result_valid <= do_store;
            last         <= do_last;
        end
    end

    always_ff @(posedge clk) begin
        if (!run) begin
            store_buf <= '0;
        end else if (do_store) begin
            store_buf <= store_vec;
        end
    end

    // zero unless a store is being presented
    assign result = result_valid ? store_buf : '0;

endmodule

`default_nettype wire

// ==== hw/hv_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module hv_core
    import hv_data_pkg::*;
    import hv_inst_pkg::*;
(
    input  wire              clk,
    input  wire              arst_n,
    // item loading
    input  wire              load_mode,
    input  wire              chunk_valid,
    input  wire hv_chunk_t   chunk,
    // instruction stream
    input  wire              run,
    input  wire              inst_valid,
    input  wire hv_inst_u    inst,
    // results
    output logic             result_valid,
    output hv_vec_t          result,
    output logic             last
);

    hv_vec_t      item_data;
    thread_idx_t  rd_thread;
    logic         ex_valid;
    hv_inst_u     ex_inst;
    thread_idx_t  ex_thread;
    hv_vec_t      store_vec;
    logic         do_store;
    logic         do_last;

    // item memory, read address straight from the incoming word
    hv_item_memory i_item_memory (
        .clk         (clk),
        .arst_n      (arst_n),
        .load_mode   (load_mode),
        .chunk_valid (chunk_valid),
        .chunk       (chunk),
        .rd_addr     (inst.ld.item_addr),
        .rd_data     (item_data)
    );

    hv_decode i_decode (
        .clk        (clk),
        .arst_n     (arst_n),
        .run        (run),
        .inst_valid (inst_valid),
        .inst       (inst),
        .rd_thread  (rd_thread),
        .ex_valid   (ex_valid),
        .ex_inst    (ex_inst),
        .ex_thread  (ex_thread)
    );

    hv_execute i_execute (
        .clk       (clk),
        .ex_valid  (ex_valid),
        .ex_inst   (ex_inst),
        .ex_thread (ex_thread),
        .rd_thread (rd_thread),
        .item_data (item_data),
        .store_vec (store_vec),
        .do_store  (do_store),
        .do_last   (do_last)
    );

    // outputs two edges after the instruction was sampled
    hv_result i_result (
        .clk          (clk),
        .arst_n       (arst_n),
        .run          (run),
        .do_store     (do_store),
        .do_last      (do_last),
        .store_vec    (store_vec),
        .result_valid (result_valid),
        .last         (last),
        .result       (result)
    );

endmodule

`default_nettype wire

// ==== verif/hv_core_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module hv_core_checker
    import hv_data_pkg::*;
(
    input  wire             clk,
    input  wire             arst_n,
    input  wire             run,
    input  wire             result_valid,
    input  wire             last,
    input  wire hv_vec_t    result
);

    int fail_count = 0;

    // store and last are exclusive
    a_one_strobe: assert property (@(posedge clk) disable iff (!arst_n)
        !(result_valid && last))
        else begin
            fail_count++;
            $error("result_valid and last are high together");
        end

    a_result_zero: assert property (@(posedge clk) disable iff (!arst_n)
        !result_valid |-> (result == '0))
        else begin
            fail_count++;
            $error("result is not zero while result_valid is low");
        end

    // strobes cleared one cycle after run drops
    a_stop_clears: assert property (@(posedge clk) disable iff (!arst_n)
        !run |=> (!result_valid && !last))
        else begin
            fail_count++;
            $error("a strobe is high in the cycle after run was low");
        end

endmodule

`default_nettype wire

// ==== verif/hv_core_monitor.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "hv_macros.svh"

module hv_core_monitor
    import hv_data_pkg::*;
(
    input  wire                     clk,
    input  wire                     arst_n,
    input  wire                     load_mode,
    input  wire                     chunk_valid,
    input  wire hv_chunk_t          chunk,
    input  wire                     run,
    input  wire                     inst_valid,
    input  wire [`HV_INST_W-1:0]    inst,
    input  wire                     result_valid,
    input  wire hv_vec_t            result,
    input  wire                     last,
    output int                      errors,
    output int                      stores,
    output int                      lasts,
    output int                      pending
);

    localparam int SLOTS = `HV_DIM / `HV_CHUNK;

    // item memory and per-thread registers as the DUT should hold them
    hv_vec_t        item_mem [`HV_ITEMS];
    hv_vec_t        r1 [`HV_THREADS];
    hv_vec_t        r2 [`HV_THREADS];
    hv_vec_t        asm_vec;
    hv_vec_t        work;
    hv_vec_t        exp_vec;
    int             slot;
    int             wr_addr;
    int             exp_kind;
    int             new_kind;
    thread_idx_t    thread;
    longint         cycle;

    // outcomes still to come: due cycle, kind (1 store, 2 last), value
    longint         due_q [$];
    int             kind_q [$];
    hv_vec_t        vec_q [$];

    function automatic hv_vec_t rotate_left(hv_vec_t v, int amt);
        hv_vec_t o;
        for (int i = 0; i < `HV_DIM; i++) begin
            o[(i + amt) % `HV_DIM] = v[i];
        end
        return o;
    endfunction

    always @(posedge clk) begin
        if (!arst_n) begin
            slot     = 0;
            wr_addr  = 0;
            asm_vec  = '0;
            thread   = '0;
            cycle    = 0;
            errors   = 0;
            stores   = 0;
            lasts    = 0;
            pending  = 0;
            due_q.delete();
            kind_q.delete();
            vec_q.delete();
        end else begin
            cycle++;
            exp_kind = 0;
            exp_vec  = '0;
            if (due_q.size() > 0 && due_q[0] == cycle) begin
                void'(due_q.pop_front());
                exp_kind = kind_q.pop_front();
                exp_vec  = vec_q.pop_front();
            end
            if (result_valid !== (exp_kind == 1) || last !== (exp_kind == 2) ||
                result !== exp_vec) begin
                errors++;
                $display("FAILED at %0d ns: expected kind %0d value %h",
                         $time, exp_kind, exp_vec);
                $display("FAILED at %0d ns: saw valid %b last %b value %h",
                         $time, result_valid, last, result);
            end
            if (result_valid === 1'b1) begin
                stores++;
            end
            if (last === 1'b1) begin
                lasts++;
            end

            // run low drops whatever is still in flight
            if (!run) begin
                thread = '0;
                due_q.delete();
                kind_q.delete();
                vec_q.delete();
            end else if (inst_valid) begin
                if (inst[15]) begin
                    r2[thread] = item_mem[inst[8:0]];
                end else begin
                    work = inst[14] ? rotate_left(r2[thread], int'(inst[9:0])) : r2[thread];
                    new_kind = inst[12] ? 1 : (inst[10] ? 2 : 0);
                    // r2 takes the old r1
                    if (inst[13]) begin
                        r2[thread] = r1[thread] ^ work;
                    end
                    if (inst[11]) begin
                        r1[thread] = work;
                    end
                    if (new_kind != 0) begin
                        due_q.push_back(cycle + 2);
                        kind_q.push_back(new_kind);
                        vec_q.push_back(new_kind == 1 ? work : '0);
                    end
                end
                thread = (thread == thread_idx_t'(`HV_THREADS - 1)) ? '0 : thread + 1'b1;
            end

            // chunk assembly, first chunk in the lowest bits
            if (!load_mode) begin
                slot    = 0;
                wr_addr = 0;
                asm_vec = '0;
            end else if (chunk_valid) begin
                asm_vec[slot*`HV_CHUNK +: `HV_CHUNK] = chunk;
                slot++;
                if (slot == SLOTS) begin
                    item_mem[wr_addr] = asm_vec;
                    wr_addr = (wr_addr + 1) % `HV_ITEMS;
                    slot    = 0;
                end
            end
            pending = due_q.size();
        end
    end

endmodule

`default_nettype wire

// ==== verif/hv_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "hv_macros.svh"

module hv_core_tb
    import hv_data_pkg::*;
();

    localparam int SLOTS        = `HV_DIM / `HV_CHUNK;
    localparam int MAX_ROWS     = 64;
    localparam int TIMEOUT      = 100;
    localparam int NO_STROBE    = 0;
    localparam int STORE_STROBE = 1;
    localparam int LAST_STROBE  = 2;

    logic                   clk;
    logic                   arst_n;
    logic                   load_mode;
    logic                   chunk_valid;
    hv_chunk_t              chunk;
    logic                   run;
    logic                   inst_valid;
    logic [`HV_INST_W-1:0]  inst;
    logic                   result_valid;
    hv_vec_t                result;
    logic                   last;

    int errors;
    int stores;
    int lasts;
    int pending;
    int timeouts;
    int exp_stores;
    int exp_lasts;
    int seed;

    // idle cycles before the row, run restart, instruction, expected strobe
    int                     nrows;
    int                     row_gap [MAX_ROWS];
    bit                     row_restart [MAX_ROWS];
    logic [`HV_INST_W-1:0]  row_inst [MAX_ROWS];
    int                     row_kind [MAX_ROWS];

    hv_core i_hv_core (
        .clk          (clk),
        .arst_n       (arst_n),
        .load_mode    (load_mode),
        .chunk_valid  (chunk_valid),
        .chunk        (chunk),
        .run          (run),
        .inst_valid   (inst_valid),
        .inst         (inst),
        .result_valid (result_valid),
        .result       (result),
        .last         (last)
    );

    hv_core_monitor i_monitor (
        .clk          (clk),
        .arst_n       (arst_n),
        .load_mode    (load_mode),
        .chunk_valid  (chunk_valid),
        .chunk        (chunk),
        .run          (run),
        .inst_valid   (inst_valid),
        .inst         (inst),
        .result_valid (result_valid),
        .result       (result),
        .last         (last),
        .errors       (errors),
        .stores       (stores),
        .lasts        (lasts),
        .pending      (pending)
    );

    bind hv_core hv_core_checker i_checker (
        .clk          (clk),
        .arst_n       (arst_n),
        .run          (run),
        .result_valid (result_valid),
        .last         (last),
        .result       (result)
    );

    always #20 clk = ~clk;

    function automatic logic [`HV_INST_W-1:0] load_word(int addr);
        return {1'b1, 6'b0, 9'(addr)};
    endfunction

    // fields from bit 14 down: rotate, wr_r2, store, wr_r1, last, amount
    function automatic logic [`HV_INST_W-1:0] op_word(bit rot, bit wr2, bit st, bit wr1,
                                                      bit lst, int amt);
        return {1'b0, rot, wr2, st, wr1, lst, 10'(amt)};
    endfunction

    task automatic add_row(int gap, bit restart, logic [`HV_INST_W-1:0] word, int kind);
        row_gap[nrows]     = gap;
        row_restart[nrows] = restart;
        row_inst[nrows]    = word;
        row_kind[nrows]    = kind;
        nrows++;
    endtask

    task automatic build_table();
        // r2 from item memory, then stored unchanged
        for (int t = 0; t < `HV_THREADS; t++) begin
            add_row(0, 0, load_word((3 * t + 1) % 8), NO_STROBE);
        end
        for (int t = 0; t < `HV_THREADS; t++) begin
            add_row(t == 2 ? 3 : 0, 0, op_word(0, 0, 1, 0, 0, 0), STORE_STROBE);
        end
        add_row(0, 0, op_word(1, 0, 1, 0, 0, 0), STORE_STROBE);
        add_row(0, 0, op_word(1, 0, 1, 0, 0, 1), STORE_STROBE);
        add_row(0, 0, op_word(1, 0, 1, 0, 0, 31), STORE_STROBE);
        add_row(0, 0, op_word(1, 0, 1, 0, 0, `HV_DIM - 1), STORE_STROBE);
        add_row(2, 0, op_word(1, 0, 1, 0, 0, 100), STORE_STROBE);
        // r1 gets a rotated r2, then r2 binds with r1, then store
        for (int t = 0; t < `HV_THREADS; t++) begin
            add_row(0, 0, op_word(1, 0, 0, 1, 0, t + 2), NO_STROBE);
        end
        for (int t = 0; t < `HV_THREADS; t++) begin
            add_row(0, 0, op_word(1, 1, 0, 0, 0, 7), NO_STROBE);
        end
        for (int t = 0; t < `HV_THREADS; t++) begin
            add_row(t == 4 ? 1 : 0, 0, op_word(0, 0, 1, 0, 0, 0), STORE_STROBE);
        end
        add_row(0, 0, op_word(0, 0, 0, 0, 1, 0), LAST_STROBE);
        add_row(0, 0, op_word(0, 0, 1, 0, 1, 0), STORE_STROBE);
        add_row(1, 0, op_word(0, 0, 0, 0, 1, 0), LAST_STROBE);
        // after the restart thread 0 still holds its r2
        add_row(0, 1, op_word(0, 0, 1, 0, 0, 0), STORE_STROBE);
        add_row(0, 0, op_word(0, 0, 0, 0, 1, 0), LAST_STROBE);
        add_row(0, 0, op_word(1, 0, 1, 0, 0, 9), STORE_STROBE);
    endtask

    task automatic load_items(int count);
        load_mode = 1'b1;
        for (int c = 0; c < count * SLOTS; c++) begin
            @(negedge clk);
            chunk_valid = 1'b1;
            chunk       = $random(seed);
        end
        @(negedge clk);
        chunk_valid = 1'b0;
        repeat (2) @(negedge clk);
        load_mode = 1'b0;
        @(negedge clk);
    endtask

    task automatic wait_for_results();
        int n;
        n = 0;
        while ((stores != exp_stores || lasts != exp_lasts || pending != 0) && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (stores != exp_stores || lasts != exp_lasts || pending != 0) begin
            timeouts++;
            $display("timed out, expected %0d stores and %0d lasts, saw %0d stores and %0d lasts",
                     exp_stores, exp_lasts, stores, lasts);
        end
    endtask

    task automatic apply_table();
        for (int r = 0; r < nrows; r++) begin
            if (row_restart[r]) begin
                inst_valid = 1'b0;
                wait_for_results();
                run = 1'b0;
                repeat (3) @(negedge clk);
            end
            if (row_gap[r] > 0) begin
                inst_valid = 1'b0;
                repeat (row_gap[r]) @(negedge clk);
            end
            run        = 1'b1;
            inst_valid = 1'b1;
            inst       = row_inst[r];
            if (row_kind[r] == STORE_STROBE) begin
                exp_stores++;
            end else if (row_kind[r] == LAST_STROBE) begin
                exp_lasts++;
            end
            @(negedge clk);
        end
        inst_valid = 1'b0;
    endtask

    initial begin
        seed        = 32'h0ecd_9656;
        clk         = 1'b0;
        arst_n      = 1'b0;
        load_mode   = 1'b0;
        chunk_valid = 1'b0;
        chunk       = '0;
        run         = 1'b0;
        inst_valid  = 1'b0;
        inst        = '0;
        timeouts    = 0;
        exp_stores  = 0;
        exp_lasts   = 0;
        nrows       = 0;
        build_table();
        repeat (16) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        // idle outputs after reset are compared by the monitor
        repeat (4) @(negedge clk);
        load_items(8);
        apply_table();
        wait_for_results();
        $display("errors %0d, assertion failures %0d, timeouts %0d, stores %0d, lasts %0d",
                 errors, i_hv_core.i_checker.fail_count, timeouts, stores, lasts);
        if (errors == 0 && timeouts == 0 && i_hv_core.i_checker.fail_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+hw
hw/hv_data_pkg.sv
hw/hv_inst_pkg.sv
hw/hv_item_memory.sv
hw/hv_decode.sv
hw/hv_execute.sv
hw/hv_result.sv
hw/hv_core.sv
verif/hv_core_checker.sv
verif/hv_core_monitor.sv
verif/hv_core_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= hv_core_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
RUN_ARGS  ?= +verilator+error+limit+100
PASS_MSG  := Simulation passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR) -o $(TOP)
	-./$(BUILD_DIR)/$(TOP) $(RUN_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "test: PASS"; \
	else \
		echo "test: FAIL, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
